// File: logic/p3_params.svh
`ifndef P3_PARAMS_SVH
`define P3_PARAMS_SVH

// Word address into one packet buffer, 512 words deep
`define P3_ADDR_WIDTH 9

// Width of one stored data word
`define P3_DATA_WIDTH 64

// Byte increment carried alongside each snooper write
`define P3_INC_WIDTH 8

// Running packet length in bytes
`define P3_PLEN_WIDTH 32

`endif

// File: logic/p3_pkg.sv
`include "p3_params.svh"

package p3_pkg;

    typedef logic [`P3_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`P3_DATA_WIDTH-1:0] data_t;
    typedef logic [`P3_INC_WIDTH-1:0]  inc_t;
    typedef logic [`P3_PLEN_WIDTH-1:0] plen_t;

    // Snooper side, write only
    typedef struct packed {
        addr_t addr;
        data_t wr_data;
        logic  wr_en;
        inc_t  byte_inc;
        logic  reset_len;
    } sn_req_t;

    // Forwarder side, read only
    typedef struct packed {
        addr_t addr;
        logic  rd_en;
    } fwd_req_t;

    // What a single buffer sees after routing
    typedef struct packed {
        addr_t addr;
        data_t wr_data;
        logic  wr_en;
        inc_t  byte_inc;
        logic  reset_len;
        logic  rd_en;
    } buf_req_t;

    typedef struct packed {
        data_t rd_data;
        logic  rd_data_vld;
        plen_t byte_len;
    } buf_rsp_t;

    typedef enum logic [1:0] {
        SEL_NONE = 2'd0,
        SEL_PING = 2'd1,
        SEL_PANG = 2'd2,
        SEL_PONG = 2'd3
    } buf_sel_e;

    typedef enum logic [1:0] {
        BUF_FREE     = 2'd0,
        BUF_FILLING  = 2'd1,
        BUF_FULL     = 2'd2,
        BUF_DRAINING = 2'd3
    } buf_state_e;

endpackage

// File: logic/p_ng.sv
`timescale 1ns/1ps

`include "p3_params.svh"

module p_ng
    import p3_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  buf_req_t req_i,
    output buf_rsp_t rsp_o
);

    localparam int DEPTH = 1 << `P3_ADDR_WIDTH;

    // Packet words, left untouched when the length restarts
    data_t mem [DEPTH];

    data_t rd_data_q;
    logic  rd_vld_q;
    plen_t byte_len_q;
    plen_t len_base;
    plen_t len_add;

    always_ff @(posedge clk) begin
        if (req_i.wr_en) begin
            mem[req_i.addr] <= req_i.wr_data;
        end
    end

    // Registered read port, data valid one cycle after rd_en
    always_ff @(posedge clk) begin
        if (req_i.rd_en) begin
            rd_data_q <= mem[req_i.addr];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_vld_q <= 1'b0;
        end else begin
            rd_vld_q <= req_i.rd_en;
        end
    end

    // A write on the restart cycle still counts toward the new length
    assign len_base = req_i.reset_len ? '0 : byte_len_q;
    assign len_add  = req_i.wr_en ? plen_t'(req_i.byte_inc) : '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            byte_len_q <= '0;
        end else if (req_i.reset_len || req_i.wr_en) begin
            byte_len_q <= len_base + len_add;
        end
    end

    assign rsp_o.rd_data     = rd_data_q;
    assign rsp_o.rd_data_vld = rd_vld_q;
    assign rsp_o.byte_len    = byte_len_q;

endmodule

// File: logic/p3ctrl.sv
`timescale 1ns/1ps

module p3ctrl
    import p3_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     sn_start_i,
    input  logic     sn_done_i,
    input  logic     fwd_start_i,
    input  logic     fwd_done_i,
    output logic     rdy_for_sn_o,
    output logic     sn_done_ack_o,
    output logic     rdy_for_fwd_o,
    output logic     fwd_done_ack_o,
    output buf_sel_e sn_sel_o,
    output buf_sel_e fwd_sel_o
);

    // Buffer index 0 is ping, 1 is pang, 2 is pong
    buf_state_e state_q [3];
    logic [1:0] sn_idx_q;
    logic [1:0] fwd_idx_q;
    logic       sn_done_ack_q;
    logic       fwd_done_ack_q;

    logic sn_free;
    logic sn_filling;
    logic fwd_full;
    logic fwd_draining;

    function automatic logic [1:0] next_idx(input logic [1:0] idx);
        return (idx == 2'd2) ? 2'd0 : idx + 2'd1;
    endfunction

    function automatic buf_sel_e idx_to_sel(input logic [1:0] idx);
        buf_sel_e sel;
        case (idx)
            2'd0:    sel = SEL_PING;
            2'd1:    sel = SEL_PANG;
            default: sel = SEL_PONG;
        endcase
        return sel;
    endfunction

    assign sn_free      = (state_q[sn_idx_q] == BUF_FREE);
    assign sn_filling   = (state_q[sn_idx_q] == BUF_FILLING);
    assign fwd_full     = (state_q[fwd_idx_q] == BUF_FULL);
    assign fwd_draining = (state_q[fwd_idx_q] == BUF_DRAINING);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 3; i++) begin
                state_q[i] <= BUF_FREE;
            end
            sn_idx_q       <= 2'd0;
            fwd_idx_q      <= 2'd0;
            sn_done_ack_q  <= 1'b0;
            fwd_done_ack_q <= 1'b0;
        end else begin
            sn_done_ack_q  <= sn_done_i && sn_filling;
            fwd_done_ack_q <= fwd_done_i && fwd_draining;

            // Snooper side of the rotation
            if (sn_start_i && sn_free) begin
                state_q[sn_idx_q] <= BUF_FILLING;
            end
            if (sn_done_i && sn_filling) begin
                state_q[sn_idx_q] <= BUF_FULL;
                sn_idx_q          <= next_idx(sn_idx_q);
            end

            // Forwarder follows in the same order, so packets leave in fill order
            if (fwd_start_i && fwd_full) begin
                state_q[fwd_idx_q] <= BUF_DRAINING;
            end
            if (fwd_done_i && fwd_draining) begin
                state_q[fwd_idx_q] <= BUF_FREE;
                fwd_idx_q          <= next_idx(fwd_idx_q);
            end
        end
    end

    assign rdy_for_sn_o   = sn_free;
    assign rdy_for_fwd_o  = fwd_full;
    assign sn_done_ack_o  = sn_done_ack_q;
    assign fwd_done_ack_o = fwd_done_ack_q;

    // Snooper also steers on its start cycle so the length clear reaches the buffer
    assign sn_sel_o  = (sn_filling || (sn_start_i && sn_free)) ?
                       idx_to_sel(sn_idx_q) : SEL_NONE;
    assign fwd_sel_o = fwd_draining ? idx_to_sel(fwd_idx_q) : SEL_NONE;

endmodule

// File: logic/muxes.sv
`timescale 1ns/1ps

module muxes
    import p3_pkg::*;
(
    input  buf_sel_e sn_sel_i,
    input  buf_sel_e fwd_sel_i,
    input  sn_req_t  sn_req_i,
    input  fwd_req_t fwd_req_i,
    input  buf_rsp_t ping_rsp_i,
    input  buf_rsp_t pang_rsp_i,
    input  buf_rsp_t pong_rsp_i,
    output buf_req_t ping_req_o,
    output buf_req_t pang_req_o,
    output buf_req_t pong_req_o,
    output buf_rsp_t fwd_rsp_o
);

    // Build the request for one buffer, idle unless a side has selected it
    function automatic buf_req_t build_req(
        input buf_sel_e me,
        input buf_sel_e sn_sel,
        input sn_req_t  sn,
        input buf_sel_e fwd_sel,
        input fwd_req_t fwd
    );
        buf_req_t req;
        req = '0;
        if (sn_sel == me) begin
            req.addr      = sn.addr;
            req.wr_data   = sn.wr_data;
            req.wr_en     = sn.wr_en;
            req.byte_inc  = sn.byte_inc;
            req.reset_len = sn.reset_len;
        end
        // Controller never hands one buffer to both sides
        if (fwd_sel == me) begin
            req.addr  = fwd.addr;
            req.rd_en = fwd.rd_en;
        end
        return req;
    endfunction

    always_comb begin
        ping_req_o = build_req(SEL_PING, sn_sel_i, sn_req_i, fwd_sel_i, fwd_req_i);
        pang_req_o = build_req(SEL_PANG, sn_sel_i, sn_req_i, fwd_sel_i, fwd_req_i);
        pong_req_o = build_req(SEL_PONG, sn_sel_i, sn_req_i, fwd_sel_i, fwd_req_i);
    end

    // Zero response when the forwarder holds nothing
    always_comb begin
        case (fwd_sel_i)
            SEL_PING: fwd_rsp_o = ping_rsp_i;
            SEL_PANG: fwd_rsp_o = pang_rsp_i;
            SEL_PONG: fwd_rsp_o = pong_rsp_i;
            default:  fwd_rsp_o = '0;
        endcase
    end

endmodule

// File: logic/p3.sv
`timescale 1ns/1ps

module p3
    import p3_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n_i,

    // Snooper
    input  addr_t sn_addr_i,
    input  data_t sn_wr_data_i,
    input  logic  sn_wr_en_i,
    input  inc_t  sn_byte_inc_i,
    input  logic  sn_done_i,
    output logic  sn_done_ack_o,
    output logic  rdy_for_sn_o,
    input  logic  rdy_for_sn_ack_i,

    // Forwarder
    input  addr_t fwd_addr_i,
    input  logic  fwd_rd_en_i,
    output data_t fwd_rd_data_o,
    output logic  fwd_rd_data_vld_o,
    output plen_t fwd_byte_len_o,
    input  logic  fwd_done_i,
    output logic  fwd_done_ack_o,
    output logic  rdy_for_fwd_o,
    input  logic  rdy_for_fwd_ack_i
);

    logic     sn_start;
    logic     fwd_start;
    buf_sel_e sn_sel;
    buf_sel_e fwd_sel;
    sn_req_t  sn_req;
    fwd_req_t fwd_req;
    buf_rsp_t fwd_rsp;
    buf_req_t ping_req;
    buf_req_t pang_req;
    buf_req_t pong_req;
    buf_rsp_t ping_rsp;
    buf_rsp_t pang_rsp;
    buf_rsp_t pong_rsp;

    // A side starts when it acks while its rdy is up
    assign sn_start  = rdy_for_sn_o && rdy_for_sn_ack_i;
    assign fwd_start = rdy_for_fwd_o && rdy_for_fwd_ack_i;

    // Snooper start doubles as the length clear for its new buffer
    assign sn_req  = '{addr: sn_addr_i, wr_data: sn_wr_data_i, wr_en: sn_wr_en_i,
                       byte_inc: sn_byte_inc_i, reset_len: sn_start};
    assign fwd_req = '{addr: fwd_addr_i, rd_en: fwd_rd_en_i};

    assign fwd_rd_data_o     = fwd_rsp.rd_data;
    assign fwd_rd_data_vld_o = fwd_rsp.rd_data_vld;
    assign fwd_byte_len_o    = fwd_rsp.byte_len;

    p3ctrl ctrlr (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .sn_start_i     (sn_start),
        .sn_done_i      (sn_done_i),
        .fwd_start_i    (fwd_start),
        .fwd_done_i     (fwd_done_i),
        .rdy_for_sn_o   (rdy_for_sn_o),
        .sn_done_ack_o  (sn_done_ack_o),
        .rdy_for_fwd_o  (rdy_for_fwd_o),
        .fwd_done_ack_o (fwd_done_ack_o),
        .sn_sel_o       (sn_sel),
        .fwd_sel_o      (fwd_sel)
    );

    muxes themux (
        .sn_sel_i   (sn_sel),
        .fwd_sel_i  (fwd_sel),
        .sn_req_i   (sn_req),
        .fwd_req_i  (fwd_req),
        .ping_rsp_i (ping_rsp),
        .pang_rsp_i (pang_rsp),
        .pong_rsp_i (pong_rsp),
        .ping_req_o (ping_req),
        .pang_req_o (pang_req),
        .pong_req_o (pong_req),
        .fwd_rsp_o  (fwd_rsp)
    );

    p_ng ping (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (ping_req),
        .rsp_o    (ping_rsp)
    );

    p_ng pang (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (pang_req),
        .rsp_o    (pang_rsp)
    );

    p_ng pong (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (pong_req),
        .rsp_o    (pong_rsp)
    );

endmodule

// File: tb/p3_tb.sv
`timescale 1ns/1ps

module p3_tb
    import p3_pkg::*;
();

    logic  clk = 1'b0;
    logic  arst_n_i;
    addr_t sn_addr_i;
    data_t sn_wr_data_i;
    logic  sn_wr_en_i;
    inc_t  sn_byte_inc_i;
    logic  sn_done_i;
    logic  sn_done_ack_o;
    logic  rdy_for_sn_o;
    logic  rdy_for_sn_ack_i;
    addr_t fwd_addr_i;
    logic  fwd_rd_en_i;
    data_t fwd_rd_data_o;
    logic  fwd_rd_data_vld_o;
    plen_t fwd_byte_len_o;
    logic  fwd_done_i;
    logic  fwd_done_ack_o;
    logic  rdy_for_fwd_o;
    logic  rdy_for_fwd_ack_i;

    // Packets as read from the stimulus file
    data_t word_q[$];
    inc_t  inc_q[$];
    int    pkt_base[$];
    int    pkt_words[$];
    plen_t pkt_len[$];

    int   err_cnt = 0;
    int   check_cnt = 0;
    int   cycle_cnt = 0;
    int   cycle_limit = 0;
    logic load_ok;

    p3 p3_i (.*);

    always #4 clk = ~clk;

    task automatic finish_run();
        $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            err_cnt++;
            finish_run();
        end
    end

    task automatic check_data(input string name, input data_t exp, input data_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input plen_t exp, input plen_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic load_stimulus(output logic ok);
        int    fd;
        int    code;
        int    count;
        int    base;
        int    inc_v;
        int    len_v;
        data_t d;
        plen_t sum;
        string line;
        ok = 1'b1;
        count = 0;
        base = 0;
        sum = '0;
        fd = $fopen("tb/p3_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb/p3_stimulus.txt");
            err_cnt++;
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 1 && line.getc(0) == "P") begin
                    code = $sscanf(line, "P %d", count);
                    base = word_q.size();
                    pkt_base.push_back(base);
                    sum = '0;
                end else if (code > 1 && line.getc(0) == "L") begin
                    code = $sscanf(line, "L %d", len_v);
                    pkt_len.push_back(plen_t'(len_v));
                    pkt_words.push_back(word_q.size() - base);
                    // The file's length must match its own byte increments
                    if (sum != plen_t'(len_v)) begin
                        $display("Stimulus packet %0d: length %0d but increments sum to %0d",
                                 pkt_len.size() - 1, len_v, sum);
                        err_cnt++;
                    end
                    if (word_q.size() - base != count) begin
                        $display("Stimulus packet %0d: word count does not match its lines",
                                 pkt_len.size() - 1);
                        err_cnt++;
                    end
                end else if (code > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%h %d", d, inc_v);
                    word_q.push_back(d);
                    inc_q.push_back(inc_t'(inc_v));
                    sum += plen_t'(inc_v);
                end
            end
            $fclose(fd);
            if (pkt_words.size() < 4) begin
                $display("The stimulus file holds fewer than four packets");
                err_cnt++;
                ok = 1'b0;
            end
        end
    endtask

    task automatic fill_packet(input int p);
        int base;
        int gap;
        base = pkt_base[p];
        while (!rdy_for_sn_o) begin
            @(negedge clk);
        end
        rdy_for_sn_ack_i = 1'b1;
        @(negedge clk);
        rdy_for_sn_ack_i = 1'b0;
        check_flag("rdy_for_sn_o", 1'b0, rdy_for_sn_o);
        for (int k = 0; k < pkt_words[p]; k++) begin
            sn_addr_i     = addr_t'(k);
            sn_wr_data_i  = word_q[base + k];
            sn_byte_inc_i = inc_q[base + k];
            sn_wr_en_i    = 1'b1;
            @(negedge clk);
            sn_wr_en_i = 1'b0;
            gap = $urandom_range(3, 0);
            repeat (gap) @(negedge clk);
        end
        sn_done_i = 1'b1;
        @(negedge clk);
        sn_done_i = 1'b0;
        check_flag("sn_done_ack_o", 1'b1, sn_done_ack_o);
        // A full buffer is waiting at the forwarder's rotation slot
        check_flag("rdy_for_fwd_o", 1'b1, rdy_for_fwd_o);
        @(negedge clk);
        check_flag("sn_done_ack_o", 1'b0, sn_done_ack_o);
    endtask

    task automatic read_word(input addr_t addr, input data_t exp);
        int gap;
        fwd_addr_i  = addr;
        fwd_rd_en_i = 1'b1;
        @(negedge clk);
        fwd_rd_en_i = 1'b0;
        check_flag("fwd_rd_data_vld_o", 1'b1, fwd_rd_data_vld_o);
        check_data("fwd_rd_data_o", exp, fwd_rd_data_o);
        gap = $urandom_range(3, 0);
        if (gap > 0) begin
            @(negedge clk);
            // Valid lasts only the one cycle after rd_en
            check_flag("fwd_rd_data_vld_o", 1'b0, fwd_rd_data_vld_o);
            repeat (gap - 1) @(negedge clk);
        end
    endtask

    task automatic drain_packet(input int p, input logic extra, input addr_t extra_addr,
                                input data_t extra_exp);
        int base;
        base = pkt_base[p];
        while (!rdy_for_fwd_o) begin
            @(negedge clk);
        end
        rdy_for_fwd_ack_i = 1'b1;
        @(negedge clk);
        rdy_for_fwd_ack_i = 1'b0;
        check_flag("rdy_for_fwd_o", 1'b0, rdy_for_fwd_o);
        // No read issued yet on this buffer
        check_flag("fwd_rd_data_vld_o", 1'b0, fwd_rd_data_vld_o);
        check_len("fwd_byte_len_o", pkt_len[p], fwd_byte_len_o);
        for (int k = 0; k < pkt_words[p]; k++) begin
            read_word(addr_t'(k), word_q[base + k]);
        end
        if (extra) begin
            read_word(extra_addr, extra_exp);
        end
        check_len("fwd_byte_len_o", pkt_len[p], fwd_byte_len_o);
        fwd_done_i = 1'b1;
        @(negedge clk);
        fwd_done_i = 1'b0;
        check_flag("fwd_done_ack_o", 1'b1, fwd_done_ack_o);
        check_flag("rdy_for_sn_o", 1'b1, rdy_for_sn_o);
        check_len("fwd_byte_len_o", '0, fwd_byte_len_o);
        @(negedge clk);
        check_flag("fwd_done_ack_o", 1'b0, fwd_done_ack_o);
    endtask

    // Neither side has started, so both requests must be ignored
    task automatic stray_access();
        sn_addr_i     = addr_t'(pkt_words[3]);
        sn_wr_data_i  = 64'hdead_beef_dead_beef;
        sn_byte_inc_i = 8'hff;
        sn_wr_en_i    = 1'b1;
        fwd_addr_i    = '0;
        fwd_rd_en_i   = 1'b1;
        @(negedge clk);
        sn_wr_en_i  = 1'b0;
        fwd_rd_en_i = 1'b0;
        check_flag("fwd_rd_data_vld_o", 1'b0, fwd_rd_data_vld_o);
        check_len("fwd_byte_len_o", '0, fwd_byte_len_o);
    endtask

    initial begin
        arst_n_i          = 1'b0;
        sn_addr_i         = '0;
        sn_wr_data_i      = '0;
        sn_wr_en_i        = 1'b0;
        sn_byte_inc_i     = '0;
        sn_done_i         = 1'b0;
        rdy_for_sn_ack_i  = 1'b0;
        fwd_addr_i        = '0;
        fwd_rd_en_i       = 1'b0;
        fwd_done_i        = 1'b0;
        rdy_for_fwd_ack_i = 1'b0;
        void'($urandom(32'h607cc883));
        load_stimulus(load_ok);
        cycle_limit = 20 * word_q.size() + 500;
        repeat (8) @(negedge clk);
        arst_n_i = 1'b1;
        if (load_ok) begin
            check_flag("rdy_for_sn_o", 1'b1, rdy_for_sn_o);
            check_flag("rdy_for_fwd_o", 1'b0, rdy_for_fwd_o);
            check_flag("fwd_rd_data_vld_o", 1'b0, fwd_rd_data_vld_o);
            fill_packet(0);
            fill_packet(1);
            fill_packet(2);
            // All three buffers full, snooper has to wait
            repeat (4) begin
                check_flag("rdy_for_sn_o", 1'b0, rdy_for_sn_o);
                @(negedge clk);
            end
            drain_packet(0, 1'b0, '0, '0);
            stray_access();
            fill_packet(3);
            drain_packet(1, 1'b0, '0, '0);
            drain_packet(2, 1'b0, '0, '0);
            // Ping still holds the first packet past the end of the fourth
            drain_packet(3, 1'b1, addr_t'(pkt_words[3]), word_q[pkt_base[0] + pkt_words[3]]);
        end
        finish_run();
    end

endmodule

// File: tb/p3_stimulus.txt
# Packet header "P <word count>", then one line per word "<data hex> <byte_inc dec>"
# Packet trailer "L <expected byte length dec>"
P 5
a0a0a0a000000000 8
a1a1a1a100000001 8
a2a2a2a200000002 8
a3a3a3a300000003 8
a4a4a4a400000004 5
L 37
P 4
b0b0b0b011110000 8
b1b1b1b111110001 8
b2b2b2b211110002 8
b3b3b3b311110003 3
L 27
P 3
c0c0c0c022220000 8
c1c1c1c122220001 8
c2c2c2c222220002 1
L 17
P 4
d0d0d0d033330000 8
d1d1d1d133330001 8
d2d2d2d233330002 8
d3d3d3d333330003 8
L 32

// File: p3.f
+incdir+logic
logic/p3_pkg.sv
logic/p_ng.sv
logic/p3ctrl.sv
logic/muxes.sv
logic/p3.sv
tb/p3_tb.sv

// File: run.sh
#!/bin/sh
# Build the p3 testbench with Verilator, run it, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module p3_tb -f p3.f -o p3_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/p3_sim > sim.log 2>&1
cat sim.log

grep -qx "All tests passed" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
